// ==== Bender.yml ====
package:
  name: ebusSubsys

sources:
  # RTL of the diagnostic bus subsystem
  - include_dirs:
      - include
    files:
      - src/ebusPkg.sv
      - src/ebusRegUnit.sv
      - src/ebusMux.sv
      - src/diagCtl.sv
      - src/ebusTop.sv

  # directed testbench, top module tb_ebusTop
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_ebusTop.sv

// ==== ebusSubsys.f ====
+incdir+include
src/ebusPkg.sv
src/ebusRegUnit.sv
src/ebusMux.sv
src/diagCtl.sv
src/ebusTop.sv
tests/tb_ebusTop.sv

// ==== include/ebus_config.svh ====
`ifndef EBUS_CONFIG_SVH
`define EBUS_CONFIG_SVH

// EBUS data word, numbered 0 (msb) to 35 (lsb) as on the real machine
`define EBUS_WIDTH 36

// unit number on the diagnostic function lines, 8 addressable units
`define EBUS_UNIT_BITS 3

// register index inside one unit, 4 registers per unit
`define EBUS_REG_BITS 2

// register units actually present behind the bus, numbered from 0
`define EBUS_NUM_UNITS 3

`endif

// ==== src/diagCtl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ebus_config.svh"

module diagCtl (
  input  wire logic                       eboxClk,
  input  wire logic                       rstN,
  // console command port
  input  wire logic                       cmdValid,
  input  wire logic                       cmdWrite,
  input  wire logic [`EBUS_UNIT_BITS-1:0] cmdUnit,
  input  wire logic [`EBUS_REG_BITS-1:0]  cmdReg,
  input  wire logic [0:`EBUS_WIDTH-1]     cmdData,
  output logic                            cmdReady,
  // console response port
  output logic                            rspValid,
  output logic [0:`EBUS_WIDTH-1]          rspData,
  output logic                            rspErr,
  input  wire logic                       rspReady,
  // broadcast diagnostic function
  output ebusPkg::ebusFuncE               diagFunc,
  output logic [`EBUS_UNIT_BITS-1:0]      diagUnit,
  output logic [`EBUS_REG_BITS-1:0]       diagReg,
  output logic [0:`EBUS_WIDTH-1]          diagData,
  // bus contents from the multiplexer
  input  wire logic [0:`EBUS_WIDTH-1]     ebusData,
  input  wire logic                       ebusAnyDriving
);
  import ebusPkg::*;

  diagStateE state;
  logic      cmdFire;
  logic      rspFire;

  assign cmdReady = (state == ST_IDLE);
  assign rspValid = (state == ST_RESP);
  assign cmdFire  = cmdValid && cmdReady;
  assign rspFire  = rspValid && rspReady;

  // control side: state, the active function and the response
  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      state    <= ST_IDLE;
      diagFunc <= FN_IDLE;
      rspData  <= '0;
      rspErr   <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (cmdFire) begin
            state    <= ST_XFER;
            diagFunc <= cmdWrite ? FN_WRITE : FN_READ;
          end
        end
        ST_XFER: begin
          // units have decoded the function by now and the bus is settled
          state    <= ST_RESP;
          diagFunc <= FN_IDLE;
          if (diagFunc == FN_READ) begin
            rspData <= ebusData;
            rspErr  <= !ebusAnyDriving;
          end else begin
            rspData <= '0;
            rspErr  <= 1'b0;
          end
        end
        ST_RESP: begin
          if (rspFire) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state    <= ST_IDLE;
          diagFunc <= FN_IDLE;
        end
      endcase
    end
  end

  // address and write data only matter while diagFunc is active
  always_ff @(posedge eboxClk) begin
    if (cmdFire) begin
      diagUnit <= cmdUnit;
      diagReg  <= cmdReg;
      diagData <= cmdData;
    end
  end

  // the console may stall, the word it sees must not change under it
  assert property (@(posedge eboxClk) disable iff (!rstN)
                   (rspValid && !rspReady) |=> ($stable(rspData) && $stable(rspErr)))
    else $error("response changed while held by the console");

  // units see a function for the XFER cycle only
  assert property (@(posedge eboxClk) disable iff (!rstN)
                   (state != ST_XFER) |-> (diagFunc == FN_IDLE))
    else $error("diagnostic function active outside XFER");

endmodule

`default_nettype wire

// ==== src/ebusMux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ebus_config.svh"

module ebusMux (
  input  wire logic                                          eboxClk,
  input  wire logic                                          rstN,
  input  wire logic [`EBUS_NUM_UNITS-1:0]                    unitDriving,
  input  wire logic [`EBUS_NUM_UNITS-1:0][0:`EBUS_WIDTH-1]   unitData,
  output logic      [0:`EBUS_WIDTH-1]                        ebusData,
  output logic                                               ebusAnyDriving
);

  // fixed priority, unit 0 first, same order as an if/else chain
  // walking down from the top so the lowest driving unit is applied last
  always_comb begin
    ebusData = '0;
    for (int i = `EBUS_NUM_UNITS - 1; i >= 0; i--) begin
      if (unitDriving[i]) begin
        ebusData = unitData[i];
      end
    end
  end

  assign ebusAnyDriving = |unitDriving;

  // the priority only hides a collision, two drivers means a decode fault
  // somewhere in the units
  assert property (@(posedge eboxClk) disable iff (!rstN)
                   $onehot0(unitDriving))
    else $error("more than one unit drives EBUS: %b", unitDriving);

endmodule

`default_nettype wire

// ==== src/ebusPkg.sv ====
`default_nettype none

`include "ebus_config.svh"

package ebusPkg;

  // diagnostic function broadcast by the controller to every unit
  typedef enum logic [1:0] {
    FN_IDLE  = 2'b00,
    FN_READ  = 2'b01,
    FN_WRITE = 2'b10
  } ebusFuncE;

  // console controller states
  // XFER lasts one cycle, RESP waits for the console to take the word
  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,
    ST_XFER = 2'b01,
    ST_RESP = 2'b10
  } diagStateE;

endpackage

`default_nettype wire

// ==== src/ebusRegUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ebus_config.svh"

module ebusRegUnit #(
  parameter int UNIT_ID = 0
) (
  input  wire logic                      eboxClk,
  input  wire logic                      rstN,
  input  wire ebusPkg::ebusFuncE         diagFunc,
  input  wire logic [`EBUS_UNIT_BITS-1:0] diagUnit,
  input  wire logic [`EBUS_REG_BITS-1:0]  diagReg,
  input  wire logic [0:`EBUS_WIDTH-1]     diagData,
  output logic                           driving,
  output logic [0:`EBUS_WIDTH-1]          data
);
  import ebusPkg::*;

  // the top register index is the identification register
  localparam logic [`EBUS_REG_BITS-1:0] ID_REG = '1;
  localparam int NUM_RW = (1 << `EBUS_REG_BITS) - 1;
  localparam logic [`EBUS_UNIT_BITS-1:0] MY_UNIT = UNIT_ID[`EBUS_UNIT_BITS-1:0];
  // unit number sits in the low-order (highest numbered) bits
  localparam logic [0:`EBUS_WIDTH-1] ID_WORD =
      {{(`EBUS_WIDTH - `EBUS_UNIT_BITS){1'b0}}, MY_UNIT};

  logic [0:`EBUS_WIDTH-1] regs [0:NUM_RW-1];
  logic                   selected;

  assign selected = (diagUnit == MY_UNIT);

  // writes land at the end of the XFER cycle and never reach the ID register
  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < NUM_RW; i++) begin
        regs[i] <= '0;
      end
    end else if (selected && diagFunc == FN_WRITE && diagReg != ID_REG) begin
      regs[diagReg] <= diagData;
    end
  end

  // read path is combinational so the bus settles within the XFER cycle
  always_comb begin
    driving = selected && (diagFunc == FN_READ);
    data    = '0;
    if (driving) begin
      if (diagReg == ID_REG) begin
        data = ID_WORD;
      end else begin
        data = regs[diagReg];
      end
    end
  end

  // a function lasts one cycle so a write lands only once
  assert property (@(posedge eboxClk) disable iff (!rstN)
                   (diagFunc != FN_IDLE) |=> (diagFunc == FN_IDLE))
    else $error("unit %0d sees a function held for more than one cycle", UNIT_ID);

endmodule

`default_nettype wire

// ==== src/ebusTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ebus_config.svh"

module ebusTop (
  input  wire logic                       eboxClk,
  input  wire logic                       rstN,
  input  wire logic                       cmdValid,
  input  wire logic                       cmdWrite,
  input  wire logic [`EBUS_UNIT_BITS-1:0] cmdUnit,
  input  wire logic [`EBUS_REG_BITS-1:0]  cmdReg,
  input  wire logic [0:`EBUS_WIDTH-1]     cmdData,
  output wire logic                       cmdReady,
  output wire logic                       rspValid,
  output wire logic [0:`EBUS_WIDTH-1]     rspData,
  output wire logic                       rspErr,
  input  wire logic                       rspReady
);
  import ebusPkg::*;

  // function lines fan out from the controller to every unit
  wire ebusFuncE                   diagFunc;
  wire logic [`EBUS_UNIT_BITS-1:0] diagUnit;
  wire logic [`EBUS_REG_BITS-1:0]  diagReg;
  wire logic [0:`EBUS_WIDTH-1]     diagData;

  // per-unit drivers, one slot per built unit
  wire logic [`EBUS_NUM_UNITS-1:0]                  unitDriving;
  wire logic [`EBUS_NUM_UNITS-1:0][0:`EBUS_WIDTH-1] unitData;

  wire logic [0:`EBUS_WIDTH-1] ebusData;
  wire logic                   ebusAnyDriving;

  diagCtl u_diagCtl (
    .eboxClk, .rstN,
    .cmdValid, .cmdWrite, .cmdUnit, .cmdReg, .cmdData, .cmdReady,
    .rspValid, .rspData, .rspErr, .rspReady,
    .diagFunc, .diagUnit, .diagReg, .diagData,
    .ebusData, .ebusAnyDriving
  );

  ebusMux u_ebusMux (
    .eboxClk, .rstN,
    .unitDriving, .unitData,
    .ebusData, .ebusAnyDriving
  );

  for (genvar i = 0; i < `EBUS_NUM_UNITS; i++) begin : gUnit
    ebusRegUnit #(
      .UNIT_ID(i)
    ) u_unit (
      .eboxClk, .rstN,
      .diagFunc, .diagUnit, .diagReg, .diagData,
      .driving(unitDriving[i]),
      .data(unitData[i])
    );
  end

endmodule

`default_nettype wire

// ==== tests/tb_ebusTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ebus_config.svh"

module tb_ebusTop;

  localparam int NUM_REGS = 1 << `EBUS_REG_BITS;
  localparam int ID_REG = NUM_REGS - 1;
  localparam int NUM_ADDR = 1 << `EBUS_UNIT_BITS;
  // about 200 transactions of 4 to 14 cycles each fit well under this limit
  localparam int MAX_CYCLES = 2000;

  logic                       eboxClk;
  logic                       rstN;
  logic                       cmdValid;
  logic                       cmdWrite;
  logic [`EBUS_UNIT_BITS-1:0] cmdUnit;
  logic [`EBUS_REG_BITS-1:0]  cmdReg;
  logic [0:`EBUS_WIDTH-1]     cmdData;
  logic                       cmdReady;
  logic                       rspValid;
  logic [0:`EBUS_WIDTH-1]     rspData;
  logic                       rspErr;
  logic                       rspReady;

  int cycleCount;

  // expected contents of every register of the built units
  logic [0:`EBUS_WIDTH-1] refRegs [0:`EBUS_NUM_UNITS-1][0:NUM_REGS-1];

  ebusTop u_dut (
    .eboxClk, .rstN,
    .cmdValid, .cmdWrite, .cmdUnit, .cmdReg, .cmdData, .cmdReady,
    .rspValid, .rspData, .rspErr, .rspReady
  );

  always #50 eboxClk = ~eboxClk;

  always @(posedge eboxClk) begin
    cycleCount++;
    if (cycleCount >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
      $display("Result: FAILED");
      $fatal(1, "simulation timeout");
    end
  end

  task automatic reportFail(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    $display("Result: FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic checkWord(input string what, input logic [0:`EBUS_WIDTH-1] exp,
                           input logic [0:`EBUS_WIDTH-1] act);
    assert (act === exp)
      else reportFail($sformatf("%s: expected %h, got %h", what, exp, act));
  endtask

  task automatic checkFlag(input string what, input logic exp, input logic act);
    assert (act === exp)
      else reportFail($sformatf("%s: expected %b, got %b", what, exp, act));
  endtask

  // absent units read as zero and built units as the model holds them
  function automatic logic [0:`EBUS_WIDTH-1] expData(input int unit, input int rg);
    if (unit < `EBUS_NUM_UNITS) begin
      return refRegs[unit][rg];
    end
    return '0;
  endfunction

  function automatic logic expErr(input int unit);
    return unit >= `EBUS_NUM_UNITS;
  endfunction

  // the identification register and absent units ignore writes
  task automatic applyWrite(input int unit, input int rg, input logic [0:`EBUS_WIDTH-1] d);
    if (unit < `EBUS_NUM_UNITS && rg != ID_REG) begin
      refRegs[unit][rg] = d;
    end
  endtask

  function automatic logic [0:`EBUS_WIDTH-1] writePattern(input int unit, input int rg);
    logic [0:`EBUS_WIDTH-1] step;
    step = unit * NUM_REGS + rg + 1;
    return (step * 36'h011111111) | 36'hA00000000;
  endfunction

  function automatic logic [0:`EBUS_WIDTH-1] randomWord();
    logic [31:0]              lo;
    logic [`EBUS_WIDTH-33:0]  hi;
    lo = $urandom;
    hi = $urandom;
    return {hi, lo};
  endfunction

  // one full command and response with rspReady low for holdCycles stalled edges
  task automatic transact(input logic wr, input int unit, input int rg,
                          input logic [0:`EBUS_WIDTH-1] d, input int holdCycles,
                          output logic [0:`EBUS_WIDTH-1] data, output logic err);
    int lat;
    @(posedge eboxClk);
    cmdValid <= 1'b1;
    cmdWrite <= wr;
    cmdUnit  <= unit[`EBUS_UNIT_BITS-1:0];
    cmdReg   <= rg[`EBUS_REG_BITS-1:0];
    cmdData  <= d;
    rspReady <= (holdCycles == 0);
    @(negedge eboxClk);
    while (!cmdReady) begin
      @(negedge eboxClk);
    end
    // the command is taken on this edge
    @(posedge eboxClk);
    cmdValid <= 1'b0;
    @(negedge eboxClk);
    lat = 1;
    while (!rspValid) begin
      @(negedge eboxClk);
      lat++;
    end
    assert (lat == 2)
      else reportFail($sformatf("rspValid rose %0d cycles after acceptance, expected 1",
                                lat - 1));
    checkFlag("cmdReady while a response is pending", 1'b0, cmdReady);
    data = rspData;
    err  = rspErr;
    // each pass is one edge where the console stalls the response
    for (int i = 0; i < holdCycles; i++) begin
      @(posedge eboxClk);
      if (i == holdCycles - 1) begin
        rspReady <= 1'b1;
      end
      @(negedge eboxClk);
      checkFlag("rspValid under back-pressure", 1'b1, rspValid);
      checkFlag("cmdReady under back-pressure", 1'b0, cmdReady);
      checkWord("rspData under back-pressure", data, rspData);
      checkFlag("rspErr under back-pressure", err, rspErr);
    end
    // response handshake edge
    @(posedge eboxClk);
    @(negedge eboxClk);
    checkFlag("cmdReady after the response", 1'b1, cmdReady);
    checkFlag("rspValid after the response", 1'b0, rspValid);
  endtask

  task automatic busWrite(input int unit, input int rg, input logic [0:`EBUS_WIDTH-1] d);
    logic [0:`EBUS_WIDTH-1] data;
    logic                   err;
    transact(1'b1, unit, rg, d, 0, data, err);
    checkFlag($sformatf("rspErr of write to unit %0d reg %0d", unit, rg), 1'b0, err);
    checkWord($sformatf("rspData of write to unit %0d reg %0d", unit, rg), '0, data);
    applyWrite(unit, rg, d);
  endtask

  task automatic busRead(input int unit, input int rg,
                         output logic [0:`EBUS_WIDTH-1] data, output logic err);
    transact(1'b0, unit, rg, '0, 0, data, err);
  endtask

  task automatic checkRead(input int unit, input int rg);
    logic [0:`EBUS_WIDTH-1] data;
    logic                   err;
    busRead(unit, rg, data, err);
    checkWord($sformatf("read of unit %0d reg %0d", unit, rg), expData(unit, rg), data);
    checkFlag($sformatf("rspErr of unit %0d reg %0d", unit, rg), expErr(unit), err);
  endtask

  task automatic checkAllUnits();
    for (int u = 0; u < `EBUS_NUM_UNITS; u++) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        checkRead(u, r);
      end
    end
  endtask

  task automatic resetState();
    @(negedge eboxClk);
    checkFlag("cmdReady after reset", 1'b1, cmdReady);
    checkFlag("rspValid after reset", 1'b0, rspValid);
    checkAllUnits();
  endtask

  // every unit is checked in full after each unit is written
  task automatic writeReadback();
    for (int u = 0; u < `EBUS_NUM_UNITS; u++) begin
      for (int r = 0; r < ID_REG; r++) begin
        busWrite(u, r, writePattern(u, r));
      end
      checkAllUnits();
    end
  endtask

  task automatic idRegisterReadOnly();
    for (int u = 0; u < `EBUS_NUM_UNITS; u++) begin
      busWrite(u, ID_REG, '1);
      checkRead(u, ID_REG);
    end
    checkAllUnits();
  endtask

  task automatic absentUnits();
    for (int u = `EBUS_NUM_UNITS; u < NUM_ADDR; u++) begin
      checkRead(u, u % NUM_REGS);
      busWrite(u, u % ID_REG, writePattern(u, 0));
    end
    checkAllUnits();
  endtask

  task automatic backPressure();
    logic [0:`EBUS_WIDTH-1] data;
    logic [0:`EBUS_WIDTH-1] word;
    logic                   err;
    transact(1'b0, 1, 2, '0, 1 + $urandom % 10, data, err);
    checkWord("held read of unit 1 reg 2", expData(1, 2), data);
    checkFlag("rspErr of held read", 1'b0, err);
    // the next command must go straight through
    checkRead(2, 1);
    word = randomWord();
    transact(1'b1, 0, 0, word, 1 + $urandom % 10, data, err);
    checkFlag("rspErr of held write", 1'b0, err);
    applyWrite(0, 0, word);
    checkRead(0, 0);
  endtask

  task automatic randomCommands();
    logic [0:`EBUS_WIDTH-1] data;
    logic [0:`EBUS_WIDTH-1] word;
    logic                   err;
    logic                   wr;
    int                     unit;
    int                     rg;
    for (int n = 0; n < 100; n++) begin
      wr   = $urandom % 2;
      unit = $urandom % NUM_ADDR;
      rg   = $urandom % NUM_REGS;
      word = randomWord();
      transact(wr, unit, rg, word, $urandom % 4, data, err);
      if (wr) begin
        checkFlag($sformatf("rspErr of random write %0d", n), 1'b0, err);
        applyWrite(unit, rg, word);
      end else begin
        checkWord($sformatf("random read %0d of unit %0d reg %0d", n, unit, rg),
                  expData(unit, rg), data);
        checkFlag($sformatf("rspErr of random read %0d", n), expErr(unit), err);
      end
    end
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(50723));
    eboxClk    = 1'b0;
    rstN       = 1'b0;
    cmdValid   = 1'b0;
    cmdWrite   = 1'b0;
    cmdUnit    = '0;
    cmdReg     = '0;
    cmdData    = '0;
    rspReady   = 1'b0;
    cycleCount = 0;
    for (int u = 0; u < `EBUS_NUM_UNITS; u++) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        refRegs[u][r] = '0;
      end
      refRegs[u][ID_REG] = u;
    end
    repeat (2) @(posedge eboxClk);
    rstN <= 1'b1;

    resetState();
    writeReadback();
    idRegisterReadOnly();
    absentUnits();
    backPressure();
    randomCommands();

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire
